// ==== Makefile ====
# Verilator build and run of the VC allocator testbench

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f vca.f --top-module vca_tb
	@out=$$(./obj_dir/Vvca_tb); \
	echo "$$out"; \
	echo "$$out" | grep -qx 'PASS: all tests'

lint:
	verilator --lint-only --timing --assert -f vca.f --top-module vca_tb

clean:
	rm -rf obj_dir

// ==== common/vc_req_if.sv ====
// ============================================================
// Routed request of one input port, seen by every output
// No handshake, a request holds until its input is granted
// ============================================================
`timescale 1ns/1ps

interface vc_req_if
	import vca_pkg::*;
();

	logic      valid;
	// Requested output port and the VC wanted on it
	port_idx_t out_port;
	vc_idx_t   out_vc;
	// Input VC sitting at route compute
	vc_idx_t   in_vc;

	// Driven from the flat router ports
	modport req (
		output valid,
		output out_port,
		output out_vc,
		output in_vc
	);

	// Read by the output allocators and the grant mapping
	modport alloc (
		input valid,
		input out_port,
		input out_vc,
		input in_vc
	);

endinterface

// ==== common/vca_pkg.sv ====
// ============================================================
// Sizes and vector types for the VC allocator of one mesh router
// Port numbers 5 to 7 are invalid and never match an output
// ============================================================

package vca_pkg;

	// ============================================================
	// Router sizes
	// ============================================================
	localparam int NUM_PORTS    = 5;
	localparam int NUM_VCS      = 2;
	// Buffer slots per downstream VC, also the counter reset value
	localparam int CREDIT_DEPTH = 4;

	// ============================================================
	// Shared vector types
	// ============================================================
	// North 0, east 1, south 2, west 3, local 4
	typedef logic [2:0] port_idx_t;

	typedef logic [$clog2(NUM_VCS)-1:0] vc_idx_t;

	// One-hot or zero over the VCs of a port
	typedef logic [NUM_VCS-1:0] vc_mask_t;

	typedef logic [NUM_PORTS-1:0] port_mask_t;

	// Holds 0 up to CREDIT_DEPTH
	typedef logic [$clog2(CREDIT_DEPTH+1)-1:0] credit_t;

	// Arbiter result when nobody requests
	localparam port_idx_t PORT_NONE = 3'd7;

endpackage

// ==== out_port_alloc/out_port_alloc.sv ====
// ============================================================
// Allocator for one output port
// Round-robin winner is granted only if its output VC has credit
// ============================================================
`timescale 1ns/1ps

module out_port_alloc
	import vca_pkg::*;
#(
	parameter port_idx_t PORT_ID = '0
) (
	input  logic     clk,
	input  logic     rst,

	vc_req_if.alloc  reqs [NUM_PORTS],
	// Credits handed back from downstream for this output
	input  vc_mask_t credit_ret,

	output logic      grant_valid,
	output port_idx_t winner,
	output vc_mask_t  available
);

	// ============================================================
	// Requests aimed at this output
	// ============================================================
	port_mask_t           req_mask;
	// Wanted output VC of each input, one bit per port
	logic [NUM_PORTS-1:0] req_vc;

	for (genvar i = 0; i < NUM_PORTS; i++) begin : g_req
		// Invalid port numbers never equal PORT_ID
		assign req_mask[i] = reqs[i].valid && (reqs[i].out_port == PORT_ID);
		assign req_vc[i]   = reqs[i].out_vc;
	end

	// ============================================================
	// Arbitration and credit check
	// ============================================================
	vc_idx_t  winner_vc;
	vc_mask_t consume;

	rr_arbiter u_rr_arbiter (
		.clk     (clk),
		.rst     (rst),
		.req     (req_mask),
		.advance (grant_valid),
		.winner  (winner)
	);

	assign winner_vc = (winner != PORT_NONE) ? req_vc[winner] : '0;

	// A winner without credit blocks the output this cycle
	assign grant_valid = (winner != PORT_NONE) && available[winner_vc];

	// Output VC taken by this grant
	assign consume = grant_valid ? (vc_mask_t'(1) << winner_vc) : '0;

	vc_credit_tracker u_vc_credit_tracker (
		.clk        (clk),
		.rst        (rst),
		.consume    (consume),
		.credit_ret (credit_ret),
		.available  (available)
	);

endmodule

// ==== out_port_alloc/rr_arbiter.sv ====
// ============================================================
// Round-robin choice among the five input ports
// Pointer holds the last granted port and moves only on advance
// ============================================================
`timescale 1ns/1ps

module rr_arbiter
	import vca_pkg::*;
(
	input  logic       clk,
	input  logic       rst,

	input  port_mask_t req,
	// Winner was actually granted this cycle
	input  logic       advance,

	output port_idx_t  winner
);

	// Last granted port, north after reset
	port_idx_t last_ptr;

	// ============================================================
	// Search starting one past the last grant
	// ============================================================
	always_comb begin
		logic        found;
		int unsigned cand;

		found  = 1'b0;
		winner = PORT_NONE;
		// Offset NUM_PORTS wraps back to the last winner itself
		for (int unsigned off = 1; off <= NUM_PORTS; off++) begin
			cand = (int'(last_ptr) + off) % NUM_PORTS;
			if (!found && req[cand]) begin
				found  = 1'b1;
				winner = port_idx_t'(cand);
			end
		end
	end

	// ============================================================
	// Pointer update
	// ============================================================
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			last_ptr <= '0;
		end else if (advance && (winner != PORT_NONE)) begin
			last_ptr <= winner;
		end
	end

	// Blocked winner keeps the pointer, so it is chosen again

endmodule

// ==== out_port_alloc/vc_credit_tracker.sv ====
// ============================================================
// Downstream credit counters for the VCs of one output port
// Returns are expected only while a count is below full depth
// ============================================================
`timescale 1ns/1ps

module vc_credit_tracker
	import vca_pkg::*;
(
	input  logic     clk,
	input  logic     rst,

	// Grant taking a slot on the VC
	input  vc_mask_t consume,
	// Slot freed downstream
	input  vc_mask_t credit_ret,

	output vc_mask_t available
);

	// ============================================================
	// One counter per VC
	// ============================================================
	for (genvar v = 0; v < NUM_VCS; v++) begin : g_vc
		credit_t count;

		always_ff @(posedge clk or posedge rst) begin
			if (rst) begin
				count <= credit_t'(CREDIT_DEPTH);
			end else begin
				// Grant and return together cancel out
				case ({credit_ret[v], consume[v]})
					2'b01:   count <= count - 1'b1;
					2'b10:   count <= count + 1'b1;
					default: count <= count;
				endcase
			end
		end

		// Any free slot downstream
		assign available[v] = (count != '0);
	end

endmodule

// ==== source/grant_router.sv ====
// ============================================================
// Maps each output's winner back to its input port
// Each input requests one output, so one output selects it at most
// ============================================================
`timescale 1ns/1ps

module grant_router
	import vca_pkg::*;
(
	vc_req_if.alloc   reqs        [NUM_PORTS],
	input  port_mask_t grant_valid,
	input  port_idx_t  winner      [NUM_PORTS],

	// Grant on the input VC at route compute
	output vc_mask_t   vc_grant    [NUM_PORTS]
);

	// ============================================================
	// Which outputs picked each input
	// ============================================================
	// sel[i][o] set when output o grants input i
	port_mask_t sel [NUM_PORTS];

	for (genvar i = 0; i < NUM_PORTS; i++) begin : g_in
		for (genvar o = 0; o < NUM_PORTS; o++) begin : g_out
			assign sel[i][o] = grant_valid[o] && (winner[o] == port_idx_t'(i));
		end

		// One-hot of the input VC, zero when not granted
		assign vc_grant[i] = (|sel[i]) ? (vc_mask_t'(1) << reqs[i].in_vc) : '0;
	end

endmodule

// ==== source/vca_top.sv ====
// ============================================================
// VC allocator for a five port, two VC mesh router node
// Grants are combinational, credits and pointers move on clk
// ============================================================
`timescale 1ns/1ps

module vca_top
	import vca_pkg::*;
(
	input  logic       clk,
	input  logic       rst,

	// Routed request per input port
	input  port_mask_t route_valid,
	input  port_idx_t  route_port   [NUM_PORTS],
	input  vc_idx_t    route_vc     [NUM_PORTS],
	input  vc_idx_t    rc_vc        [NUM_PORTS],

	// Credit returns per output port
	input  vc_mask_t   out_credits  [NUM_PORTS],

	// Input VC grant per input port
	output vc_mask_t   vc_grant     [NUM_PORTS],
	// Output VCs that still hold credit
	output vc_mask_t   vc_available [NUM_PORTS]
);

	// ============================================================
	// Request bundles
	// ============================================================
	vc_req_if req_if [NUM_PORTS] ();

	for (genvar i = 0; i < NUM_PORTS; i++) begin : g_req
		assign req_if[i].valid    = route_valid[i];
		assign req_if[i].out_port = route_port[i];
		assign req_if[i].out_vc   = route_vc[i];
		assign req_if[i].in_vc    = rc_vc[i];
	end

	// ============================================================
	// One allocator per output port
	// ============================================================
	port_mask_t grant_valid;
	port_idx_t  winner [NUM_PORTS];

	for (genvar o = 0; o < NUM_PORTS; o++) begin : g_out
		out_port_alloc #(
			.PORT_ID (port_idx_t'(o))
		) u_out_port_alloc (
			.clk         (clk),
			.rst         (rst),
			.reqs        (req_if),
			.credit_ret  (out_credits[o]),
			.grant_valid (grant_valid[o]),
			.winner      (winner[o]),
			.available   (vc_available[o])
		);
	end

	// ============================================================
	// Winners back to input VC grants
	// ============================================================
	grant_router u_grant_router (
		.reqs        (req_if),
		.grant_valid (grant_valid),
		.winner      (winner),
		.vc_grant    (vc_grant)
	);

endmodule

// ==== tb/vca_sva.sv ====
// ============================================================
// Port level assertions for the VC allocator, bound into vca_top
// ============================================================
`timescale 1ns/1ps

module vca_sva
	import vca_pkg::*;
(
	input logic       clk,
	input logic       rst,
	input port_mask_t route_valid,
	input vc_mask_t   vc_grant     [NUM_PORTS],
	input vc_mask_t   vc_available [NUM_PORTS]
);

	// ============================================================
	// Per input and per output checks
	// ============================================================
	for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
		// Only one input VC sits at route compute
		a_grant_onehot: assert property (
			@(posedge clk) disable iff (rst)
			$onehot0(vc_grant[i])
		) else $error("grant on input %0d is not one-hot", i);

		a_grant_needs_req: assert property (
			@(posedge clk) disable iff (rst)
			(|vc_grant[i]) |-> route_valid[i]
		) else $error("grant on input %0d without a valid request", i);

		// Counters at full depth while in reset
		a_reset_state: assert property (
			@(posedge clk)
			rst |-> ((vc_grant[i] == '0) && (vc_available[i] == '1))
		) else $error("port %0d not in reset state during reset", i);
	end

endmodule

bind vca_top vca_sva u_vca_sva (
	.clk          (clk),
	.rst          (rst),
	.route_valid  (route_valid),
	.vc_grant     (vc_grant),
	.vc_available (vc_available)
);

// ==== tb/vca_tb.sv ====
// ============================================================
// Testbench for the VC allocator, directed cases then random traffic
// A reference model of pointers and credit counts checks each rising edge
// ============================================================
`timescale 1ns/1ps

module vca_tb
	import vca_pkg::*;
();

	// Directed part and reset take about 40 cycles, random part 1500
	localparam int RANDOM_CYCLES  = 1500;
	localparam int TIMEOUT_CYCLES = 5000;

	logic       clk;
	logic       rst;
	port_mask_t route_valid;
	port_idx_t  route_port   [NUM_PORTS];
	vc_idx_t    route_vc     [NUM_PORTS];
	vc_idx_t    rc_vc        [NUM_PORTS];
	vc_mask_t   out_credits  [NUM_PORTS];
	vc_mask_t   vc_grant     [NUM_PORTS];
	vc_mask_t   vc_available [NUM_PORTS];

	// Reference model state
	int         credit_cnt   [NUM_PORTS][NUM_VCS];
	port_idx_t  rr_ptr       [NUM_PORTS];
	vc_mask_t   exp_grant    [NUM_PORTS];
	logic       granted_q    [NUM_PORTS];

	int         cycles = 0;
	integer     seed;

	vca_top UUT (
		.clk          (clk),
		.rst          (rst),
		.route_valid  (route_valid),
		.route_port   (route_port),
		.route_vc     (route_vc),
		.rc_vc        (rc_vc),
		.out_credits  (out_credits),
		.vc_grant     (vc_grant),
		.vc_available (vc_available)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ============================================================
	// Reference model and compare tasks
	// ============================================================
	// Round-robin pick for output o, credit not considered
	function automatic port_idx_t pick_winner(input int o);
		int cand;
		for (int off = 1; off <= NUM_PORTS; off++) begin
			cand = (int'(rr_ptr[o]) + off) % NUM_PORTS;
			if (route_valid[cand] && (route_port[cand] == port_idx_t'(o)))
				return port_idx_t'(cand);
		end
		return PORT_NONE;
	endfunction

	task automatic reset_model();
		for (int o = 0; o < NUM_PORTS; o++) begin
			rr_ptr[o]    = '0;
			exp_grant[o] = '0;
			granted_q[o] = 1'b0;
			for (int v = 0; v < NUM_VCS; v++)
				credit_cnt[o][v] = CREDIT_DEPTH;
		end
	endtask

	task automatic check_grant(input int idx, input vc_mask_t got, input vc_mask_t exp);
		if (got !== exp) begin
			$display("ERROR: vc_grant[%0d] = %h, expected %h", idx, got, exp);
			$display("FAIL: see errors above");
			$fatal(1, "vc_grant mismatch");
		end
	endtask

	task automatic check_avail(input int idx, input vc_mask_t got, input vc_mask_t exp);
		if (got !== exp) begin
			$display("ERROR: vc_available[%0d] = %h, expected %h", idx, got, exp);
			$display("FAIL: see errors above");
			$fatal(1, "vc_available mismatch");
		end
	endtask

	always @(posedge clk) begin : compare_outputs
		port_idx_t w;
		logic      gv  [NUM_PORTS];
		vc_idx_t   gvc [NUM_PORTS];
		port_idx_t gw  [NUM_PORTS];
		vc_mask_t  exp_avail;

		if (rst) begin
			reset_model();
		end else begin
			for (int i = 0; i < NUM_PORTS; i++)
				exp_grant[i] = '0;
			// Winner is granted only while its output VC holds credit
			for (int o = 0; o < NUM_PORTS; o++) begin
				w      = pick_winner(o);
				gv[o]  = 1'b0;
				gvc[o] = '0;
				gw[o]  = w;
				if (w != PORT_NONE) begin
					gvc[o] = route_vc[w];
					if (credit_cnt[o][gvc[o]] > 0) begin
						gv[o]        = 1'b1;
						exp_grant[w] = vc_mask_t'(1) << rc_vc[w];
					end
				end
			end
			for (int i = 0; i < NUM_PORTS; i++) begin
				check_grant(i, vc_grant[i], exp_grant[i]);
				granted_q[i] = |exp_grant[i];
			end
			for (int o = 0; o < NUM_PORTS; o++) begin
				for (int v = 0; v < NUM_VCS; v++)
					exp_avail[v] = (credit_cnt[o][v] > 0);
				check_avail(o, vc_available[o], exp_avail);
			end
			// State as it stands after this edge
			for (int o = 0; o < NUM_PORTS; o++) begin
				for (int v = 0; v < NUM_VCS; v++) begin
					if (gv[o] && (int'(gvc[o]) == v))
						credit_cnt[o][v] = credit_cnt[o][v] - 1;
					if (out_credits[o][v])
						credit_cnt[o][v] = credit_cnt[o][v] + 1;
				end
				if (gv[o])
					rr_ptr[o] = gw[o];
			end
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
			$display("FAIL: see errors above");
			$fatal(1, "timeout");
		end
	end

	// ============================================================
	// Stimulus
	// ============================================================
	task automatic clear_inputs();
		route_valid = '0;
		for (int i = 0; i < NUM_PORTS; i++) begin
			route_port[i]  = '0;
			route_vc[i]    = '0;
			rc_vc[i]       = '0;
			out_credits[i] = '0;
		end
	endtask

	task automatic drive_request(input int i, input port_idx_t p, input vc_idx_t ovc,
		input vc_idx_t ivc);
		route_valid[i] = 1'b1;
		route_port[i]  = p;
		route_vc[i]    = ovc;
		rc_vc[i]       = ivc;
	endtask

	task automatic release_granted();
		for (int i = 0; i < NUM_PORTS; i++)
			if (granted_q[i])
				route_valid[i] = 1'b0;
	endtask

	task automatic drive_random();
		for (int i = 0; i < NUM_PORTS; i++) begin
			// Granted or unroutable requests leave the input
			if (granted_q[i] || (route_port[i] >= port_idx_t'(NUM_PORTS)))
				route_valid[i] = 1'b0;
			if (!route_valid[i] && (($unsigned($random(seed)) % 3) == 0)) begin
				drive_request(i, port_idx_t'($unsigned($random(seed)) % 6),
					vc_idx_t'($random(seed) & 1), vc_idx_t'($random(seed) & 1));
			end
		end
		// Return only while downstream is not full
		for (int o = 0; o < NUM_PORTS; o++)
			for (int v = 0; v < NUM_VCS; v++)
				out_credits[o][v] = (credit_cnt[o][v] < CREDIT_DEPTH) &&
					(($random(seed) & 1) == 1);
	endtask

	initial begin
		seed = 32'hb1f32737;
		rst  = 1'b1;
		clear_inputs();
		repeat (10) @(negedge clk);
		rst = 1'b0;

		#5;
		for (int i = 0; i < NUM_PORTS; i++) begin
			check_avail(i, vc_available[i], 2'b11);
			check_grant(i, vc_grant[i], 2'b00);
		end

		// Lone request south to north, then one to an invalid port
		@(negedge clk);
		drive_request(2, 3'd0, 1'b1, 1'b1);
		#5 check_grant(2, vc_grant[2], 2'b10);
		@(negedge clk);
		route_valid = '0;
		drive_request(1, 3'd6, 1'b0, 1'b0);
		#5 check_grant(1, vc_grant[1], 2'b00);

		// North, east and west share local, east goes first
		@(negedge clk);
		route_valid = '0;
		drive_request(0, 3'd4, 1'b0, 1'b0);
		drive_request(1, 3'd4, 1'b0, 1'b0);
		drive_request(3, 3'd4, 1'b0, 1'b0);
		#5 check_grant(1, vc_grant[1], 2'b01);
		@(negedge clk);
		release_granted();
		#5 check_grant(3, vc_grant[3], 2'b01);
		repeat (2) begin
			@(negedge clk);
			release_granted();
		end
		repeat (3) begin
			@(negedge clk);
			out_credits[4] = 2'b01;
		end

		// Drain south VC 1, then a return unblocks it
		@(negedge clk);
		out_credits[4] = '0;
		drive_request(0, 3'd2, 1'b1, 1'b0);
		repeat (4) @(negedge clk);
		#5;
		check_avail(2, vc_available[2], 2'b01);
		check_grant(0, vc_grant[0], 2'b00);
		@(negedge clk);
		out_credits[2] = 2'b10;
		@(negedge clk);
		out_credits[2] = '0;
		#5 check_grant(0, vc_grant[0], 2'b01);

		// Grant and return in one cycle keep the count at one
		@(negedge clk);
		route_valid    = '0;
		out_credits[2] = 2'b10;
		@(negedge clk);
		drive_request(0, 3'd2, 1'b1, 1'b0);
		#5 check_grant(0, vc_grant[0], 2'b01);
		@(negedge clk);
		route_valid    = '0;
		out_credits[2] = '0;
		#5 check_avail(2, vc_available[2], 2'b11);

		// A single further grant then empties the VC
		@(negedge clk);
		drive_request(0, 3'd2, 1'b1, 1'b0);
		#5 check_grant(0, vc_grant[0], 2'b01);
		@(negedge clk);
		route_valid = '0;
		#5 check_avail(2, vc_available[2], 2'b01);

		repeat (RANDOM_CYCLES) begin
			@(negedge clk);
			drive_random();
		end
		@(negedge clk);
		clear_inputs();
		@(negedge clk);
		$display("PASS: all tests");
		$finish;
	end

endmodule

// ==== vca.f ====
common/vca_pkg.sv
common/vc_req_if.sv
out_port_alloc/rr_arbiter.sv
out_port_alloc/vc_credit_tracker.sv
out_port_alloc/out_port_alloc.sv
source/grant_router.sv
source/vca_top.sv
tb/vca_sva.sv
tb/vca_tb.sv
